// ==== rtl/agc_settings.svh ====
`ifndef AGC_SETTINGS_SVH
`define AGC_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Loop targets and step sizes
////////////////////////////////////////////////////////////////////////////

`define AGC_START_SCALE     17'd1500        // Scale written on the first pass
`define AGC_START_OFFSET    16'sd0          // Offset written on the first pass
`define AGC_SCALE_DELTA     17'd30          // Scale step per iteration
`define AGC_OFFSET_DELTA    16'sd25         // Offset step, signed

// Mean square target and half-width of the accepted band
`define AGC_TARGET_RMS_SQ   32'd16
`define AGC_RMS_SQ_ERR      32'd0
`define AGC_OFFSET_ERR      32'd5           // Dead band on the gt/lt counts
`define AGC_TS_RED_BITS     4               // Sum of squares is pre-scaled by 2^4

// Scale clamps
`define AGC_SCALE_MIN       32'd300
`define AGC_SCALE_MAX       32'h0001_FBD0

`define AGC_BOOT_CYCLES     31              // Idle cycles before the first command

////////////////////////////////////////////////////////////////////////////
// AGC block register map and control words
////////////////////////////////////////////////////////////////////////////

`define AGC_ADDR_CTRL       8'h00
`define AGC_ADDR_SCALE      8'h10
`define AGC_ADDR_OFFSET     8'h14

`define AGC_CMD_RESET       32'h0000_0004   // Clear statistics
`define AGC_CMD_START       32'h0000_0001   // Begin a sample period
`define AGC_CMD_LOAD        32'h0000_0300   // Load scale and offset
`define AGC_CMD_APPLY       32'h0000_0400   // Apply loaded values

// Status bit 1 flags the end of the sample period
`define AGC_DONE_BIT        1

`endif

// ==== rtl/agc_bus_pkg.sv ====
package agc_bus_pkg;

    // Data word on both the downstream bus and the host port
    typedef logic [31:0] agc_word_t;

    // Host side register address
    typedef logic [7:0] host_addr_t;

    // One downstream transfer as handed to the bus master
    typedef struct packed {
        logic       write;      // 1 = write, 0 = read
        logic [7:0] addr;       // Byte address in the AGC block
        agc_word_t  data;       // Write data, ignored on reads
    } agc_cmd_t;

endpackage

// ==== rtl/agc_loop_pkg.sv ====
package agc_loop_pkg;

    // Statistics record read from the AGC block
    // Word 1 holds the sum of squares, words 2 and 3 the gt/lt counts,
    // words 4 and 5 the scale and offset currently in use
    typedef agc_bus_pkg::agc_word_t [5:0] agc_info_t;

    // Gain pair written back each iteration
    typedef struct packed {
        logic        [16:0] scale;
        logic signed [15:0] offset;
    } agc_gains_t;

    // Control loop states, in the order they are walked
    typedef enum logic [3:0] {
        boot,
        write_scale,
        write_offset,
        load,
        apply,
        reset_stats,
        start,
        poll,
        read_info,
        calc
    } loop_state_t;

endpackage

// ==== rtl/agc_bus_master.sv ====
`timescale 1ns/1ps

module agc_bus_master (
    input  logic                   aclk,
    input  logic                   wb_rst_i,
    input  logic                   agc_reset_i,
    input  logic                   go_i,
    input  agc_bus_pkg::agc_cmd_t  cmd_i,
    input  logic                   agc_ack_i,
    input  agc_bus_pkg::agc_word_t agc_rdata_i,
    output logic                   agc_req_o,
    output agc_bus_pkg::agc_cmd_t  agc_cmd_o,
    output logic                   done_o,
    output agc_bus_pkg::agc_word_t rdata_o
);

    typedef enum logic [1:0] {
        m_idle,
        m_wait_ack,
        m_wait_release
    } mst_state_t;

    mst_state_t state;

    // Four-phase handshake engine
    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            state     <= m_idle;
            agc_req_o <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                m_idle: if (go_i) begin
                    agc_req_o <= 1'b1;
                    state     <= m_wait_ack;
                end
                m_wait_ack: if (agc_ack_i) begin
                    agc_req_o <= 1'b0;              // Release on the clock after ack
                    state     <= m_wait_release;
                end
                m_wait_release: if (!agc_ack_i) begin
                    done_o <= 1'b1;                 // Block has let go, next go is safe
                    state  <= m_idle;
                end
                default: state <= m_idle;
            endcase
        end
    end

    // Command is frozen for the whole transfer
    always_ff @(posedge aclk) begin
        if (state == m_idle && go_i) agc_cmd_o <= cmd_i;
        if (state == m_wait_ack && agc_ack_i) rdata_o <= agc_rdata_i;   // Valid with ack
    end

endmodule

// ==== rtl/agc_gain_calc.sv ====
`timescale 1ns/1ps
`include "agc_settings.svh"

module agc_gain_calc (
    input  agc_loop_pkg::agc_info_t  info_i,
    output agc_loop_pkg::agc_gains_t gains_o
);

    import agc_bus_pkg::*;

    agc_word_t power;

    // Sum of squares over the period, brought back to a mean square
    assign power = info_i[1] >> (17 - `AGC_TS_RED_BITS);

    ////////////////////////////////////////////////////////////////////////////
    // Scale, stepped toward the target band and clamped
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        gains_o.scale = info_i[4][16:0];            // In band, keep current scale
        if (power > `AGC_TARGET_RMS_SQ + `AGC_RMS_SQ_ERR) begin
            if (info_i[4] > `AGC_SCALE_MIN) begin
                gains_o.scale = 17'(info_i[4] - `AGC_SCALE_DELTA);
            end
        end else if (power < (`AGC_TARGET_RMS_SQ - `AGC_RMS_SQ_ERR)) begin
            if (info_i[4] < `AGC_SCALE_MAX) begin
                gains_o.scale = 17'(info_i[4] + `AGC_SCALE_DELTA);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Offset, balanced on the gt/lt counts
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        gains_o.offset = info_i[5][15:0];
        if (info_i[2] > info_i[3] + `AGC_OFFSET_ERR) begin
            gains_o.offset = info_i[5][15:0] - `AGC_OFFSET_DELTA;    // Too many above
        end else if (info_i[3] > info_i[2] + `AGC_OFFSET_ERR) begin
            gains_o.offset = info_i[5][15:0] + `AGC_OFFSET_DELTA;    // Too many below
        end
    end

endmodule

// ==== rtl/agc_loop_sequencer.sv ====
`timescale 1ns/1ps
`include "agc_settings.svh"

module agc_loop_sequencer (
    input  logic                     aclk,
    input  logic                     wb_rst_i,
    input  logic                     agc_reset_i,
    input  logic                     done_i,
    input  agc_bus_pkg::agc_word_t   rdata_i,
    input  agc_loop_pkg::agc_gains_t gains_i,
    output logic                     go_o,
    output agc_bus_pkg::agc_cmd_t    cmd_o,
    output agc_loop_pkg::agc_info_t  info_o
);

    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    loop_state_t state;
    logic        busy;          // A transfer is out with the bus master
    logic [4:0]  boot_cnt;
    logic [2:0]  info_idx;
    agc_gains_t  gains;         // Values for the next scale/offset writes
    agc_info_t   info;

    assign info_o = info;

    // One go per command state; busy drops it the clock after
    assign go_o = !busy && (state != boot) && (state != calc);

    ////////////////////////////////////////////////////////////////////////////
    // Command for the current state
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        cmd_o.write = 1'b1;
        cmd_o.addr  = `AGC_ADDR_CTRL;
        cmd_o.data  = '0;
        case (state)
            write_scale: begin
                cmd_o.addr = `AGC_ADDR_SCALE;
                cmd_o.data = {15'd0, gains.scale};
            end
            write_offset: begin
                cmd_o.addr = `AGC_ADDR_OFFSET;
                cmd_o.data = {{16{gains.offset[15]}}, gains.offset};
            end
            load:        cmd_o.data = `AGC_CMD_LOAD;
            apply:       cmd_o.data = `AGC_CMD_APPLY;
            reset_stats: cmd_o.data = `AGC_CMD_RESET;
            start:       cmd_o.data = `AGC_CMD_START;
            poll:        cmd_o.write = 1'b0;            // Status read at 0x00
            read_info: begin
                cmd_o.write = 1'b0;
                cmd_o.addr  = {3'b000, info_idx, 2'b00};
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Loop state machine
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            state        <= boot;
            busy         <= 1'b0;
            boot_cnt     <= 5'(`AGC_BOOT_CYCLES - 1);  // Req follows the exit by a clock
            info_idx     <= '0;
            gains.scale  <= `AGC_START_SCALE;
            gains.offset <= `AGC_START_OFFSET;
        end else begin
            if (go_o) busy <= 1'b1;
            case (state)
                boot: begin
                    if (boot_cnt != 5'd0) boot_cnt <= boot_cnt - 5'd1;
                    else state <= write_scale;
                end
                calc: begin
                    gains <= gains_i;               // Single cycle, calc is combinational
                    state <= write_scale;
                end
                default: if (done_i) begin
                    busy <= 1'b0;
                    case (state)
                        write_scale:  state <= write_offset;
                        write_offset: state <= load;
                        load:         state <= apply;
                        apply:        state <= reset_stats;
                        reset_stats:  state <= start;
                        start:        state <= poll;
                        poll: if (rdata_i[`AGC_DONE_BIT]) begin
                            info_idx <= '0;
                            state    <= read_info;
                        end
                        read_info: begin
                            if (info_idx == 3'd5) state <= calc;
                            info_idx <= info_idx + 3'd1;
                        end
                        default: state <= boot;
                    endcase
                end
            endcase
        end
    end

    // Statistics record
    always_ff @(posedge aclk) begin
        if (done_i && state == read_info) info[info_idx] <= rdata_i;
        if (done_i && state == apply) begin
            info[4] <= {15'd0, gains.scale};        // Gains now live in the block
            info[5] <= {{16{gains.offset[15]}}, gains.offset};
        end
    end

endmodule

// ==== rtl/agc_reg_target.sv ====
`timescale 1ns/1ps
`include "agc_settings.svh"

module agc_reg_target (
    input  logic                    aclk,
    input  logic                    wb_rst_i,
    input  logic                    host_req_i,
    input  agc_bus_pkg::host_addr_t host_addr_i,
    input  agc_loop_pkg::agc_info_t info_i,
    output logic                    host_ack_o,
    output agc_bus_pkg::agc_word_t  host_rdata_o
);

    import agc_bus_pkg::*;

    logic [3:0] idx;
    agc_word_t  rd_word;

    assign idx = host_addr_i[5:2];

    // Bit 6 selects the loop step sizes, else the statistics record
    always_comb begin
        rd_word = '0;
        if (host_addr_i[6]) begin
            case (idx)
                4'd0:    rd_word = 32'(`AGC_SCALE_DELTA);
                4'd1:    rd_word = 32'(`AGC_OFFSET_DELTA);   // Sign extends
                default: rd_word = '0;
            endcase
        end else if (idx < 4'd6) begin
            rd_word = info_i[idx[2:0]];
        end
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            host_ack_o <= 1'b0;
        end else if (host_req_i && !host_ack_o) begin
            host_ack_o <= 1'b1;
        end else if (!host_req_i && host_ack_o) begin
            host_ack_o <= 1'b0;                     // Four-phase release
        end
    end

    always_ff @(posedge aclk) begin
        if (host_req_i && !host_ack_o) host_rdata_o <= rd_word;
    end

endmodule

// ==== rtl/agc_ctrl_top.sv ====
`timescale 1ns/1ps

module agc_ctrl_top (
    input  logic                    aclk,
    input  logic                    wb_rst_i,
    input  logic                    agc_reset_i,
    input  logic                    agc_ack_i,
    input  agc_bus_pkg::agc_word_t  agc_rdata_i,
    input  logic                    host_req_i,
    input  agc_bus_pkg::host_addr_t host_addr_i,
    output logic                    agc_req_o,
    output agc_bus_pkg::agc_cmd_t   agc_cmd_o,
    output logic                    host_ack_o,
    output agc_bus_pkg::agc_word_t  host_rdata_o
);

    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    logic       go;
    logic       done;
    agc_cmd_t   seq_cmd;
    agc_word_t  rd_word;        // Read word returned by the master
    agc_info_t  info;
    agc_gains_t gains;

    agc_loop_sequencer agc_loop_sequencer_inst (
        .aclk        (aclk),
        .wb_rst_i    (wb_rst_i),
        .agc_reset_i (agc_reset_i),
        .done_i      (done),
        .rdata_i     (rd_word),
        .gains_i     (gains),
        .go_o        (go),
        .cmd_o       (seq_cmd),
        .info_o      (info)
    );

    agc_bus_master agc_bus_master_inst (
        .aclk        (aclk),
        .wb_rst_i    (wb_rst_i),
        .agc_reset_i (agc_reset_i),
        .go_i        (go),
        .cmd_i       (seq_cmd),
        .agc_ack_i   (agc_ack_i),
        .agc_rdata_i (agc_rdata_i),
        .agc_req_o   (agc_req_o),
        .agc_cmd_o   (agc_cmd_o),
        .done_o      (done),
        .rdata_o     (rd_word)
    );

    agc_gain_calc agc_gain_calc_inst (
        .info_i  (info),
        .gains_o (gains)
    );

    // Host port runs beside the loop and never waits on it
    agc_reg_target agc_reg_target_inst (
        .aclk         (aclk),
        .wb_rst_i     (wb_rst_i),
        .host_req_i   (host_req_i),
        .host_addr_i  (host_addr_i),
        .info_i       (info),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o)
    );

endmodule

// ==== tb/agc_ctrl_properties.sv ====
`timescale 1ns/1ps

module agc_ctrl_properties (
    input logic                  aclk, wb_rst_i, agc_reset_i,
    input logic                  agc_req_o, agc_ack_i, host_req_i, host_ack_o,
    input agc_bus_pkg::agc_cmd_t agc_cmd_o
);

    int unsigned fail_count = 0;        // Read by the testbench for its summary

    ////////////////////////////////////////////////////////////////////////////
    // Downstream four-phase handshake
    ////////////////////////////////////////////////////////////////////////////
    assert property (@(posedge aclk) disable iff (wb_rst_i || agc_reset_i)
        agc_req_o && !agc_ack_i |=> agc_req_o) else begin
        $error("agc_req_o dropped before agc_ack_i was seen");
        fail_count++;
    end

    // Command must not move under a pending request
    assert property (@(posedge aclk) disable iff (wb_rst_i || agc_reset_i)
        agc_req_o |=> !agc_req_o || $stable(agc_cmd_o)) else begin
        $error("agc_cmd_o changed while agc_req_o was high");
        fail_count++;
    end

    assert property (@(posedge aclk) disable iff (wb_rst_i || agc_reset_i)
        $rose(agc_req_o) |-> !$past(agc_ack_i)) else begin
        $error("agc_req_o rose while agc_ack_i was still high");
        fail_count++;
    end

    // Host ack only answers a live request
    assert property (@(posedge aclk) disable iff (wb_rst_i)
        $rose(host_ack_o) |-> $past(host_req_i)) else begin
        $error("host_ack_o rose without host_req_i");
        fail_count++;
    end

endmodule

bind agc_ctrl_top agc_ctrl_properties agc_ctrl_properties_inst (.*);

// ==== tb/agc_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "agc_settings.svh"

module agc_ctrl_tb;

    import agc_bus_pkg::*;

    logic       aclk, wb_rst_i, agc_reset_i, agc_ack_i, agc_req_o, host_req_i, host_ack_o;
    agc_word_t  agc_rdata_i, host_rdata_o, exp_scale, exp_offset;
    host_addr_t host_addr_i;
    agc_cmd_t   agc_cmd_o, cmd;     // cmd is the last command the block model took
    integer     seed = 32'hb713_430e;
    int         errors = 0;
    logic       timed_out = 1'b0;
    string      stall_msg;

    // Statistics words 0 to 5 served on each pass
    agc_word_t stats [3][6] = '{
        '{32'h11, 32'h0005_0000, 32'd100, 32'd10, 32'd1500, 32'd0},         // Power 40 too high
        '{32'h22, 32'h0000_6000, 32'd10, 32'd100, 32'd1470, 32'hFFFF_FFE7}, // Power 3 too low
        '{32'h33, 32'h0005_0000, 32'd50, 32'd48, 32'd300, 32'd7}};          // Scale at floor
    agc_word_t next_scale [3] = '{32'd1470, 32'd1500, 32'd300};
    agc_word_t next_offset [3] = '{32'hFFFF_FFE7, 32'd0, 32'd7};

    agc_ctrl_top agc_ctrl_top_inst (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    task automatic compare_word(input string name, input agc_word_t got, input agc_word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic step_wait(input int limit, inout int cycles, input string what);
        @(negedge aclk);
        cycles++;
        if (cycles > limit && !timed_out) begin
            stall_msg = what;
            timed_out = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // AGC block model
    ////////////////////////////////////////////////////////////////////////////
    task automatic wait_req(output int cycles);
        cycles = 0;
        while (!agc_req_o && !timed_out) step_wait(100, cycles, "no agc_req_o from the DUT");
        cmd = agc_cmd_o;
    endtask

    task automatic ack_req(input agc_word_t data);
        int cycles;
        cycles = 0;
        repeat (1 + $unsigned($random(seed)) % 4) @(negedge aclk);     // Ack latency 1 to 4
        agc_rdata_i = data;
        agc_ack_i   = 1'b1;
        while (agc_req_o && !timed_out) step_wait(20, cycles, "agc_req_o held after ack");
        repeat ($unsigned($random(seed)) % 4) @(negedge aclk);         // Late release 0 to 3
        agc_ack_i = 1'b0;
    endtask

    task automatic check_cmd(input logic wr, input logic [7:0] addr, input agc_word_t data);
        int cycles;
        wait_req(cycles);
        compare_word("agc_cmd_o.write", 32'(cmd.write), 32'(wr));
        compare_word("agc_cmd_o.addr", 32'(cmd.addr), 32'(addr));
        if (wr) compare_word("agc_cmd_o.data", cmd.data, data);
    endtask

    task automatic serve(input logic wr, input logic [7:0] addr, input agc_word_t data,
                         input agc_word_t rdata);
        check_cmd(wr, addr, data);
        ack_req(rdata);
    endtask

    task automatic host_read(input host_addr_t addr, input agc_word_t exp);
        int cycles;
        cycles = 0;
        host_addr_i = addr;
        host_req_i  = 1'b1;
        while (!host_ack_o && !timed_out) step_wait(10, cycles, "no host_ack_o");
        compare_word("host_rdata_o", host_rdata_o, exp);
        host_req_i = 1'b0;
        while (host_ack_o && !timed_out) step_wait(20, cycles, "host_ack_o held after req");
    endtask

    // One full loop iteration with host reads while reset_stats is pending
    task automatic run_pass(input int n);
        serve(1'b1, `AGC_ADDR_SCALE, exp_scale, '0);
        serve(1'b1, `AGC_ADDR_OFFSET, exp_offset, '0);
        serve(1'b1, `AGC_ADDR_CTRL, `AGC_CMD_LOAD, '0);
        serve(1'b1, `AGC_ADDR_CTRL, `AGC_CMD_APPLY, '0);
        check_cmd(1'b1, `AGC_ADDR_CTRL, `AGC_CMD_RESET);
        host_read(8'h10, exp_scale);
        host_read(8'h14, exp_offset);
        host_read(8'h40, 32'(`AGC_SCALE_DELTA));
        host_read(8'h44, 32'(`AGC_OFFSET_DELTA));
        host_read(8'h18, 32'd0);                // Index 6 is unmapped
        ack_req('0);
        serve(1'b1, `AGC_ADDR_CTRL, `AGC_CMD_START, '0);
        repeat ($unsigned($random(seed)) % 4) serve(1'b0, 8'h00, '0, $random(seed) & ~32'h2);
        serve(1'b0, `AGC_ADDR_CTRL, '0, 32'h2);
        for (int i = 0; i < 6; i++) serve(1'b0, 8'(4 * i), '0, stats[n][i]);
        exp_scale  = next_scale[n];
        exp_offset = next_offset[n];
    endtask

    task automatic finish_run();
        int fails;
        fails = errors + int'(agc_ctrl_top_inst.agc_ctrl_properties_inst.fail_count);
        $display("Summary: %0d check errors, %0d assertion failures", errors, fails - errors);
        if (fails == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    initial begin
        wait (timed_out);
        $display("Timeout: %s", stall_msg);
        finish_run();
    end

    initial begin
        int cycles;
        {agc_reset_i, agc_ack_i, host_req_i} = '0;
        agc_rdata_i = '0;
        host_addr_i = '0;
        wb_rst_i    = 1'b1;
        exp_scale   = 32'(`AGC_START_SCALE);
        exp_offset  = 32'(`AGC_START_OFFSET);
        repeat (8) @(negedge aclk);
        compare_word("agc_req_o", 32'(agc_req_o), 32'd0);
        compare_word("host_ack_o", 32'(host_ack_o), 32'd0);
        wb_rst_i = 1'b0;
        wait_req(cycles);
        compare_word("boot delay", 32'(cycles), 32'(`AGC_BOOT_CYCLES + 1));
        for (int n = 0; n < 3; n++) run_pass(n);
        serve(1'b1, `AGC_ADDR_SCALE, exp_scale, '0);
        serve(1'b1, `AGC_ADDR_OFFSET, exp_offset, '0);
        check_cmd(1'b1, `AGC_ADDR_CTRL, `AGC_CMD_LOAD);
        agc_reset_i = 1'b1;                     // Loop reset with load still pending
        @(negedge aclk);
        agc_reset_i = 1'b0;
        wait_req(cycles);
        compare_word("boot delay", 32'(cycles), 32'(`AGC_BOOT_CYCLES + 1));
        serve(1'b1, `AGC_ADDR_SCALE, 32'(`AGC_START_SCALE), '0);
        serve(1'b1, `AGC_ADDR_OFFSET, 32'(`AGC_START_OFFSET), '0);
        @(negedge aclk);
        finish_run();
    end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/agc_bus_pkg.sv
rtl/agc_loop_pkg.sv
rtl/agc_bus_master.sv
rtl/agc_gain_calc.sv
rtl/agc_loop_sequencer.sv
rtl/agc_reg_target.sv
rtl/agc_ctrl_top.sv
tb/agc_ctrl_properties.sv
tb/agc_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -f build.f --top-module agc_ctrl_tb -o agc_ctrl_sim \
    && ./obj_dir/agc_ctrl_sim | tee /dev/stderr | grep -q -F '*** PASSED ***' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
